// ==== verif/pcb_stim.txt ====
# columns: cmd a b in hex. A id n = n requests granting id onward, F = request that fails
# W/R addr = write or read check, C id cnt, L id = release, N cnt = free count, P n = idle
N 10 0
A 0 10
N 0 0
F 0 0
W 00 0
W 01 0
W 3f 0
R 00 0
R 01 0
R 3f 0
R 00 0
P 2 0
C 3 1
L 3 0
N 0 0
P 1 0
N 0 0
P 1 0
N 1 0
A 3 1
C 7 3
L 7 0
P 3 0
N 0 0
L 7 0
P 3 0
N 0 0
L 7 0
P 3 0
N 1 0
C 9 2
L 9 0
L 9 0
P 3 0
N 2 0
C 4 1
L 4 0
P 3 0
N 3 0
A 7 1
A 9 1
A 4 1
F 0 0
N 0 0

// ==== sources.f ====
rtl/pcb_pkg.sv
rtl/pkt_buffer_ram.sv
rtl/free_buf_fifo.sv
rtl/bufid_alloc.sv
rtl/bufid_release.sv
rtl/pkt_centralized_buffer.sv
verif/pcb_tb.sv

// ==== Bender.yml ====
package:
  name: pkt_centralized_buffer

sources:
  - files:
      - rtl/pcb_pkg.sv
      - rtl/pkt_buffer_ram.sv
      - rtl/free_buf_fifo.sv
      - rtl/bufid_alloc.sv
      - rtl/bufid_release.sv
      - rtl/pkt_centralized_buffer.sv
  - target: test
    files:
      - verif/pcb_tb.sv

// ==== verif/pcb_tb.sv ====
// Packet centralized buffer testbench
// Runs the command list from the stimulus file against the top level.
// Expected ids and pool levels come from the file, packet words from an LFSR.

`timescale 1ns/1ns

module pcb_tb;
        import pcb_pkg::*;

        logic      clk_sys = 1'b0;
        logic      i_rst_n;
        logic      i_alloc_req;
        logic      o_bufid_vld;
        bufid_t    o_bufid;
        logic      o_alloc_fail;
        logic      i_pkt_wr;
        pkt_addr_t i_pkt_wr_addr;
        pkt_t      i_pkt;
        logic      i_pkt_rd;
        pkt_addr_t i_pkt_rd_addr;
        logic      o_pkt_vld;
        pkt_t      o_pkt;
        logic      i_ref_wr;
        bufid_t    i_ref_bufid;
        ref_cnt_t  i_ref_cnt;
        logic      i_rel_wr;
        bufid_t    i_rel_bufid;
        free_cnt_t o_free_cnt;

        pkt_t        shadow [PKT_DEPTH];                // last word written per address
        pkt_t        rd_exp_q [$];
        int          alloc_exp_q [$];                   // -1 means a fail is due
        logic [31:0] lfsr = 32'h1efc;
        int          err_cnt = 0;
        int          check_cnt = 0;
        int          cycle_cnt = 0;
        int          cycle_limit = 100;
        int          n_lines = 0;
        int          fd;
        string       line;
        logic        alloc_due;
        logic        rd_due;
        int          exp_id;
        pkt_t        exp_word;

        pkt_centralized_buffer dut_i (.*);

        always #10 clk_sys = ~clk_sys;

        ////////////////////////////////////////
        // helpers
        ////////////////////////////////////////
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        endfunction

        task automatic make_pkt_word(output pkt_t w);
                for (int i = 0; i < PKT_W; i++) begin
                        w[i] = lfsr[0];                 // one step per bit
                        lfsr = lfsr_next(lfsr);
                end
        endtask

        task automatic next_cycle();
                @(posedge clk_sys);
                #2;
        endtask

        task automatic run_line(input string text);
                string       cmd;
                logic [31:0] a;
                logic [31:0] b;
                pkt_t        word;
                if (text.len() > 1 && text.getc(0) != "#" &&
                    $sscanf(text, "%s %h %h", cmd, a, b) == 3) begin
                        case (cmd)
                                "A": begin
                                        for (int i = 0; i < b; i++) begin
                                                i_alloc_req = 1'b1;
                                                alloc_exp_q.push_back((a + i) % BUF_NUM);
                                                next_cycle();
                                        end
                                        i_alloc_req = 1'b0;
                                end
                                "F": begin
                                        i_alloc_req = 1'b1;
                                        alloc_exp_q.push_back(-1);
                                        next_cycle();
                                        i_alloc_req = 1'b0;
                                end
                                "W": begin
                                        make_pkt_word(word);
                                        shadow[a[ADDR_W-1:0]] = word;
                                        i_pkt_wr      = 1'b1;
                                        i_pkt_wr_addr = a[ADDR_W-1:0];
                                        i_pkt         = word;
                                        next_cycle();
                                        i_pkt_wr      = 1'b0;
                                end
                                "R": begin
                                        rd_exp_q.push_back(shadow[a[ADDR_W-1:0]]);
                                        i_pkt_rd      = 1'b1;
                                        i_pkt_rd_addr = a[ADDR_W-1:0];
                                        next_cycle();
                                        i_pkt_rd      = 1'b0;
                                end
                                "C": begin
                                        i_ref_wr    = 1'b1;
                                        i_ref_bufid = a[BUFID_W-1:0];
                                        i_ref_cnt   = b[REF_W-1:0];
                                        next_cycle();
                                        i_ref_wr    = 1'b0;
                                end
                                "L": begin
                                        i_rel_wr    = 1'b1;
                                        i_rel_bufid = a[BUFID_W-1:0];
                                        next_cycle();
                                        i_rel_wr    = 1'b0;
                                end
                                "N": begin
                                        check_cnt++;
                                        if (o_free_cnt !== free_cnt_t'(a)) begin
                                                $display("FAIL o_free_cnt expected %h actual %h",
                                                         free_cnt_t'(a), o_free_cnt);
                                                err_cnt++;
                                        end
                                end
                                "P": repeat (a) next_cycle();
                                default: begin
                                        $display("unknown command %s in stimulus file", cmd);
                                        err_cnt++;
                                end
                        endcase
                end
        endtask

        ////////////////////////////////////////
        // response monitor
        ////////////////////////////////////////
        always @(posedge clk_sys) begin
                alloc_due = i_alloc_req;                // inputs settle 2 ns later
                rd_due    = i_pkt_rd;
                cycle_cnt++;
                if (cycle_cnt > cycle_limit) begin
                        $display("timeout after %0d cycles, the command list did not finish",
                                 cycle_cnt);
                        $display("TEST RESULT: FAIL");
                        $finish;
                end
        end

        always @(negedge clk_sys) begin
                if (i_rst_n && alloc_due) begin
                        exp_id = alloc_exp_q.pop_front();
                        check_cnt++;
                        if (exp_id < 0 && (!o_alloc_fail || o_bufid_vld)) begin
                                $display("request on an empty pool was not answered by a fail");
                                err_cnt++;
                        end else if (exp_id >= 0 && (!o_bufid_vld || o_alloc_fail)) begin
                                $display("request expecting id %h got no grant", exp_id);
                                err_cnt++;
                        end else if (exp_id >= 0 && o_bufid !== bufid_t'(exp_id)) begin
                                $display("FAIL o_bufid expected %h actual %h",
                                         bufid_t'(exp_id), o_bufid);
                                err_cnt++;
                        end
                end else if (i_rst_n && (o_bufid_vld || o_alloc_fail)) begin
                        $display("allocation answer strobe without a request");
                        err_cnt++;
                end
                if (i_rst_n && rd_due) begin
                        exp_word = rd_exp_q.pop_front();
                        check_cnt++;
                        if (!o_pkt_vld) begin
                                $display("o_pkt_vld missing one cycle after a read");
                                err_cnt++;
                        end else if (o_pkt !== exp_word) begin
                                $display("FAIL o_pkt expected %h actual %h", exp_word, o_pkt);
                                err_cnt++;
                        end
                end else if (i_rst_n && o_pkt_vld) begin
                        $display("o_pkt_vld strobe without a read");
                        err_cnt++;
                end
        end

        ////////////////////////////////////////
        // main sequence
        ////////////////////////////////////////
        initial begin
                i_rst_n       = 1'b0;
                i_alloc_req   = 1'b0;
                i_pkt_wr      = 1'b0;
                i_pkt_wr_addr = '0;
                i_pkt         = '0;
                i_pkt_rd      = 1'b0;
                i_pkt_rd_addr = '0;
                i_ref_wr      = 1'b0;
                i_ref_bufid   = '0;
                i_ref_cnt     = '0;
                i_rel_wr      = 1'b0;
                i_rel_bufid   = '0;
                fd = $fopen("verif/pcb_stim.txt", "r");
                if (fd == 0) begin
                        $display("cannot open stimulus file verif/pcb_stim.txt");
                        err_cnt++;
                end else begin
                        while (!$feof(fd)) begin
                                if ($fgets(line, fd) > 0) begin
                                        n_lines++;
                                end
                        end
                        $fclose(fd);
                        cycle_limit = n_lines * 8 + 100;        // sized from the list
                        fd = $fopen("verif/pcb_stim.txt", "r");
                end
                repeat (2) @(posedge clk_sys);
                #2;
                i_rst_n = 1'b1;
                if (fd != 0) begin
                        while (!$feof(fd)) begin
                                if ($fgets(line, fd) > 0) begin
                                        run_line(line);
                                end
                        end
                        $fclose(fd);
                end
                repeat (3) next_cycle();                // let last answers arrive
                if (alloc_exp_q.size() != 0 || rd_exp_q.size() != 0) begin
                        $display("some requests or reads were never answered");
                        err_cnt++;
                end
                $display("checks %0d errors %0d", check_cnt, err_cnt);
                if (err_cnt == 0) begin
                        $display("TEST RESULT: PASS");
                end else begin
                        $display("TEST RESULT: FAIL");
                end
                $finish;
        end

endmodule

// ==== rtl/pkt_centralized_buffer.sv ====
// Packet centralized buffer top
// Packet RAM beside a free buffer id pool, an allocator that hands
// ids out and a reference counter that takes them back

`timescale 1ns/1ns

module pkt_centralized_buffer
        import pcb_pkg::*;
(
        input  logic      clk_sys,
        input  logic      i_rst_n,
        // allocation
        input  logic      i_alloc_req,
        output logic      o_bufid_vld,
        output bufid_t    o_bufid,
        output logic      o_alloc_fail,
        // packet write
        input  logic      i_pkt_wr,
        input  pkt_addr_t i_pkt_wr_addr,
        input  pkt_t      i_pkt,
        // packet read
        input  logic      i_pkt_rd,
        input  pkt_addr_t i_pkt_rd_addr,
        output logic      o_pkt_vld,
        output pkt_t      o_pkt,
        // reference count from lookup table
        input  logic      i_ref_wr,
        input  bufid_t    i_ref_bufid,
        input  ref_cnt_t  i_ref_cnt,
        // release
        input  logic      i_rel_wr,
        input  bufid_t    i_rel_bufid,
        // status
        output free_cnt_t o_free_cnt
);

        logic   push_rel2fifo;
        bufid_t push_bufid_rel2fifo;
        logic   pop_alloc2fifo;
        bufid_t head_bufid_fifo2alloc;
        logic   empty_fifo2alloc;

        pkt_buffer_ram pkt_buffer_ram_i (
                .clk_sys       (clk_sys),
                .i_rst_n       (i_rst_n),
                .i_pkt_wr      (i_pkt_wr),
                .i_pkt_wr_addr (i_pkt_wr_addr),
                .i_pkt         (i_pkt),
                .i_pkt_rd      (i_pkt_rd),
                .i_pkt_rd_addr (i_pkt_rd_addr),
                .o_pkt_vld     (o_pkt_vld),
                .o_pkt         (o_pkt)
        );

        free_buf_fifo free_buf_fifo_i (
                .clk_sys      (clk_sys),
                .i_rst_n      (i_rst_n),
                .i_push       (push_rel2fifo),
                .i_push_bufid (push_bufid_rel2fifo),
                .i_pop        (pop_alloc2fifo),
                .o_head_bufid (head_bufid_fifo2alloc),
                .o_empty      (empty_fifo2alloc),
                .o_free_cnt   (o_free_cnt)
        );

        bufid_alloc bufid_alloc_i (
                .clk_sys      (clk_sys),
                .i_rst_n      (i_rst_n),
                .i_alloc_req  (i_alloc_req),
                .i_head_bufid (head_bufid_fifo2alloc),
                .i_empty      (empty_fifo2alloc),
                .o_pop        (pop_alloc2fifo),
                .o_bufid_vld  (o_bufid_vld),
                .o_bufid      (o_bufid),
                .o_alloc_fail (o_alloc_fail)
        );

        bufid_release bufid_release_i (
                .clk_sys      (clk_sys),
                .i_rst_n      (i_rst_n),
                .i_ref_wr     (i_ref_wr),
                .i_ref_bufid  (i_ref_bufid),
                .i_ref_cnt    (i_ref_cnt),
                .i_rel_wr     (i_rel_wr),
                .i_rel_bufid  (i_rel_bufid),
                .o_push       (push_rel2fifo),
                .o_push_bufid (push_bufid_rel2fifo)
        );

endmodule

// ==== rtl/bufid_release.sv ====
// Buffer id release
// Keeps a reference count per buffer id. The lookup table sets it,
// each release lowers it through a two stage pipeline, and the id
// is pushed back to the free pool when the last user lets go.

`timescale 1ns/1ns

module bufid_release
        import pcb_pkg::*;
(
        input  logic     clk_sys,
        input  logic     i_rst_n,
        // count write from lookup table
        input  logic     i_ref_wr,
        input  bufid_t   i_ref_bufid,
        input  ref_cnt_t i_ref_cnt,
        // release strobe
        input  logic     i_rel_wr,
        input  bufid_t   i_rel_bufid,
        // push to free pool
        output logic     o_push,
        output bufid_t   o_push_bufid
);

        ref_cnt_t ref_cnt [BUF_NUM];

        logic     s1_vld;                               // stage one, read
        bufid_t   s1_bufid;
        ref_cnt_t s1_cnt;
        logic     s1_last;
        ref_cnt_t s1_dec;
        logic     s2_vld;                               // stage two, write back
        bufid_t   s2_bufid;
        ref_cnt_t s2_cnt;
        ref_cnt_t rd_cnt;

        ////////////////////////////////////////
        // stage one read with forwarding
        ////////////////////////////////////////
        // releases still in flight have not reached the array yet
        always_comb begin
                if (s1_vld && s1_bufid == i_rel_bufid) begin
                        rd_cnt = s1_dec;                // one cycle ahead
                end else if (s2_vld && s2_bufid == i_rel_bufid) begin
                        rd_cnt = s2_cnt;                // writes at this edge
                end else begin
                        rd_cnt = ref_cnt[i_rel_bufid];
                end
        end

        assign s1_last = (s1_cnt <= ref_cnt_t'(1));     // 0 or 1 is last user
        assign s1_dec  = s1_last ? '0 : s1_cnt - 1'b1;

        ////////////////////////////////////////
        // pipeline registers
        ////////////////////////////////////////
        always_ff @(posedge clk_sys or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        s1_vld <= 1'b0;
                        s2_vld <= 1'b0;
                        o_push <= 1'b0;
                end else begin
                        s1_vld <= i_rel_wr;
                        s2_vld <= s1_vld;
                        o_push <= s1_vld && s1_last;    // pool sees it next edge
                end
        end

        always_ff @(posedge clk_sys) begin
                s1_bufid <= i_rel_bufid;
                s1_cnt   <= rd_cnt;
                s2_bufid <= s1_bufid;
                s2_cnt   <= s1_dec;
        end

        assign o_push_bufid = s2_bufid;

        ////////////////////////////////////////
        // reference count array
        ////////////////////////////////////////
        always_ff @(posedge clk_sys or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        for (int i = 0; i < BUF_NUM; i++) begin
                                ref_cnt[i] <= '0;
                        end
                end else begin
                        if (i_ref_wr) begin
                                ref_cnt[i_ref_bufid] <= i_ref_cnt;
                        end
                        if (s2_vld) begin
                                ref_cnt[s2_bufid] <= s2_cnt;
                        end
                end
        end

        // a lookup write to an id with a release still being retired
        // would be lost behind the write back
        a_no_wr_clash: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
                !(i_ref_wr && s2_vld && i_ref_bufid == s2_bufid));

endmodule

// ==== rtl/bufid_alloc.sv ====
// Buffer id allocator
// Answers each allocation strobe with a granted id from the
// free pool or a fail strobe, one cycle later

`timescale 1ns/1ns

module bufid_alloc
        import pcb_pkg::*;
(
        input  logic   clk_sys,
        input  logic   i_rst_n,
        input  logic   i_alloc_req,
        // free pool head
        input  bufid_t i_head_bufid,
        input  logic   i_empty,
        output logic   o_pop,
        // answer
        output logic   o_bufid_vld,
        output bufid_t o_bufid,
        output logic   o_alloc_fail
);

        logic grant;

        // decided in the request cycle, empty wins over a same-cycle push
        assign grant = i_alloc_req && !i_empty;
        assign o_pop = grant;                           // head leaves the pool now

        always_ff @(posedge clk_sys or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_bufid_vld  <= 1'b0;
                        o_alloc_fail <= 1'b0;
                end else begin
                        o_bufid_vld  <= grant;
                        o_alloc_fail <= i_alloc_req && i_empty;
                end
        end

        always_ff @(posedge clk_sys) begin
                if (grant) begin
                        o_bufid <= i_head_bufid;        // hold id with the strobe
                end
        end

endmodule

// ==== rtl/free_buf_fifo.sv ====
// Free buffer id FIFO
// Circular pool of unused buffer ids, first-word-fall-through.
// Reset loads every id in ascending order, so the pool starts full.
// Also reports how many ids are currently free.

`timescale 1ns/1ns

module free_buf_fifo
        import pcb_pkg::*;
(
        input  logic      clk_sys,
        input  logic      i_rst_n,
        // push side, from release logic
        input  logic      i_push,
        input  bufid_t    i_push_bufid,
        // pop side, from allocator
        input  logic      i_pop,
        output bufid_t    o_head_bufid,
        output logic      o_empty,
        output free_cnt_t o_free_cnt
);

        bufid_t    fifo_mem [BUF_NUM];
        bufid_t    wr_ptr;                              // wraps at BUF_NUM
        bufid_t    rd_ptr;
        free_cnt_t free_cnt;

        ////////////////////////////////////////
        // storage and pointers
        ////////////////////////////////////////
        always_ff @(posedge clk_sys or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        for (int i = 0; i < BUF_NUM; i++) begin
                                fifo_mem[i] <= bufid_t'(i);     // ids 0..15
                        end
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (i_push) begin
                                fifo_mem[wr_ptr] <= i_push_bufid;
                                wr_ptr           <= wr_ptr + 1'b1;
                        end
                        if (i_pop) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                end
        end

        ////////////////////////////////////////
        // fill level
        ////////////////////////////////////////
        always_ff @(posedge clk_sys or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        free_cnt <= free_cnt_t'(BUF_NUM);       // full after reset
                end else begin
                        case ({i_push, i_pop})
                                2'b10:   free_cnt <= free_cnt + 1'b1;
                                2'b01:   free_cnt <= free_cnt - 1'b1;
                                default: free_cnt <= free_cnt;  // both or none
                        endcase
                end
        end

        assign o_head_bufid = fifo_mem[rd_ptr];         // fall-through head
        assign o_empty      = (free_cnt == '0);
        assign o_free_cnt   = free_cnt;

        // release logic must never return an id that is already in the pool
        a_no_push_full: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
                !(i_push && free_cnt == free_cnt_t'(BUF_NUM)));

        // allocator must turn an empty pool into a fail, not a pop
        a_no_pop_empty: assert property (@(posedge clk_sys) disable iff (!i_rst_n)
                !(i_pop && o_empty));

endmodule

// ==== rtl/pkt_buffer_ram.sv ====
// Packet buffer RAM
// Shared storage for packet words, addressed by {bufid, line}.
// One write port, one read port with a registered output.

`timescale 1ns/1ns

module pkt_buffer_ram
        import pcb_pkg::*;
(
        input  logic      clk_sys,
        input  logic      i_rst_n,
        // write port
        input  logic      i_pkt_wr,
        input  pkt_addr_t i_pkt_wr_addr,
        input  pkt_t      i_pkt,
        // read port
        input  logic      i_pkt_rd,
        input  pkt_addr_t i_pkt_rd_addr,
        output logic      o_pkt_vld,
        output pkt_t      o_pkt
);

        pkt_t pkt_mem [PKT_DEPTH];                      // BUF_NUM x 4 words

        ////////////////////////////////////////
        // write side
        ////////////////////////////////////////
        always_ff @(posedge clk_sys) begin
                if (i_pkt_wr) begin
                        pkt_mem[i_pkt_wr_addr] <= i_pkt;
                end
        end

        ////////////////////////////////////////
        // read side
        ////////////////////////////////////////
        // same address as a write in this cycle returns the old word
        always_ff @(posedge clk_sys) begin
                if (i_pkt_rd) begin
                        o_pkt <= pkt_mem[i_pkt_rd_addr];
                end
        end

        always_ff @(posedge clk_sys or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_pkt_vld <= 1'b0;
                end else begin
                        o_pkt_vld <= i_pkt_rd;          // one cycle after strobe
                end
        end

endmodule

// ==== rtl/pcb_pkg.sv ====
// Packet centralized buffer shared definitions
// Widths, buffer counts and the data types passed between
// the packet RAM, the free id pool and the release logic

package pcb_pkg;

        ////////////////////////////////////////
        // sizes
        ////////////////////////////////////////
        localparam int PKT_W      = 134;                // one packet word
        localparam int BUF_NUM    = 16;                 // buffers in the pool
        localparam int BUFID_W    = 4;                  // log2 of BUF_NUM
        localparam int LINE_W     = 2;                  // four words per buffer
        localparam int ADDR_W     = BUFID_W + LINE_W;   // bufid in upper bits
        localparam int REF_W      = 4;
        localparam int FREE_CNT_W = 5;                  // holds 0..BUF_NUM
        localparam int PKT_DEPTH  = BUF_NUM << LINE_W;  // words in packet RAM

        ////////////////////////////////////////
        // types
        ////////////////////////////////////////
        typedef logic [PKT_W-1:0]      pkt_t;
        typedef logic [BUFID_W-1:0]    bufid_t;
        typedef logic [ADDR_W-1:0]     pkt_addr_t;
        typedef logic [REF_W-1:0]      ref_cnt_t;
        typedef logic [FREE_CNT_W-1:0] free_cnt_t;

endpackage
